// ==== design/csr_pkg.sv ====
package csr_pkg;

    // data and field widths
    localparam int XLEN       = 32;
    localparam int CSR_NUM_W  = 14;
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;
    localparam int HWI_W      = 8;
    localparam int INT_W      = 13;

    // csr numbers, save registers follow CSR_SAVE0
    typedef enum logic [CSR_NUM_W-1:0] {
        CSR_CRMD   = 14'h0,
        CSR_PRMD   = 14'h1,
        CSR_ECFG   = 14'h4,
        CSR_ESTAT  = 14'h5,
        CSR_ERA    = 14'h6,
        CSR_BADV   = 14'h7,
        CSR_EENTRY = 14'hc,
        CSR_SAVE0  = 14'h30,
        CSR_TID    = 14'h40,
        CSR_TCFG   = 14'h41,
        CSR_TVAL   = 14'h42,
        CSR_TICLR  = 14'h44
    } csr_addr_e;

    typedef enum logic [ECODE_W-1:0] {
        ECODE_INT  = 6'h0,
        ECODE_ADEF = 6'h8,
        ECODE_ALE  = 6'h9,
        ECODE_SYS  = 6'hb,
        ECODE_BRK  = 6'hc,
        ECODE_INE  = 6'hd
    } ecode_e;

    // new value where mask is set, old value elsewhere
    function automatic logic [XLEN-1:0] masked_merge(
        input logic [XLEN-1:0] old_value,
        input logic [XLEN-1:0] wvalue,
        input logic [XLEN-1:0] wmask
    );
        return (wvalue & wmask) | (old_value & ~wmask);
    endfunction

endpackage

// ==== design/csr_decode.sv ====
`timescale 1ns/1ps

module csr_decode import csr_pkg::*; #(
    parameter int NUM_SAVE = 4
) (
    input  logic                           csr_re,
    input  logic                           csr_we,
    input  csr_addr_e                      csr_num,
    input  logic [XLEN-1:0]                crmd_rd,
    input  logic [XLEN-1:0]                prmd_rd,
    input  logic [XLEN-1:0]                ecfg_rd,
    input  logic [XLEN-1:0]                estat_rd,
    input  logic [XLEN-1:0]                era_rd,
    input  logic [XLEN-1:0]                badv_rd,
    input  logic [XLEN-1:0]                eentry_rd,
    input  logic [NUM_SAVE-1:0][XLEN-1:0]  save_rd,
    input  logic [XLEN-1:0]                tid_rd,
    input  logic [XLEN-1:0]                tcfg_rd,
    input  logic [XLEN-1:0]                tval_rd,
    output logic [XLEN-1:0]                csr_rvalue,
    output logic                           wr_crmd,
    output logic                           wr_prmd,
    output logic                           wr_ecfg,
    output logic                           wr_estat,
    output logic                           wr_era,
    output logic                           wr_badv,
    output logic                           wr_eentry,
    output logic [NUM_SAVE-1:0]            wr_save,
    output logic                           wr_tid,
    output logic                           wr_tcfg,
    output logic                           wr_ticlr
);

    logic                hit_crmd;
    logic                hit_prmd;
    logic                hit_ecfg;
    logic                hit_estat;
    logic                hit_era;
    logic                hit_badv;
    logic                hit_eentry;
    logic [NUM_SAVE-1:0] hit_save;
    logic                hit_tid;
    logic                hit_tcfg;
    logic                hit_tval;
    logic                hit_ticlr;
    logic [XLEN-1:0]     rdata;

    assign hit_crmd   = (csr_num == CSR_CRMD);
    assign hit_prmd   = (csr_num == CSR_PRMD);
    assign hit_ecfg   = (csr_num == CSR_ECFG);
    assign hit_estat  = (csr_num == CSR_ESTAT);
    assign hit_era    = (csr_num == CSR_ERA);
    assign hit_badv   = (csr_num == CSR_BADV);
    assign hit_eentry = (csr_num == CSR_EENTRY);
    assign hit_tid    = (csr_num == CSR_TID);
    assign hit_tcfg   = (csr_num == CSR_TCFG);
    assign hit_tval   = (csr_num == CSR_TVAL);
    assign hit_ticlr  = (csr_num == CSR_TICLR);

    // save registers sit at consecutive numbers
    always_comb begin
        for (int i = 0; i < NUM_SAVE; i++) begin
            hit_save[i] = (csr_num == CSR_NUM_W'(CSR_SAVE0 + i));
        end
    end

    assign wr_crmd   = csr_we & hit_crmd;
    assign wr_prmd   = csr_we & hit_prmd;
    assign wr_ecfg   = csr_we & hit_ecfg;
    assign wr_estat  = csr_we & hit_estat;
    assign wr_era    = csr_we & hit_era;
    assign wr_badv   = csr_we & hit_badv;
    assign wr_eentry = csr_we & hit_eentry;
    assign wr_save   = {NUM_SAVE{csr_we}} & hit_save;
    assign wr_tid    = csr_we & hit_tid;
    assign wr_tcfg   = csr_we & hit_tcfg;
    assign wr_ticlr  = csr_we & hit_ticlr;

    // ticlr has no read term, reads zero
    always_comb begin
        rdata = ({XLEN{hit_crmd}}   & crmd_rd)
              | ({XLEN{hit_prmd}}   & prmd_rd)
              | ({XLEN{hit_ecfg}}   & ecfg_rd)
              | ({XLEN{hit_estat}}  & estat_rd)
              | ({XLEN{hit_era}}    & era_rd)
              | ({XLEN{hit_badv}}   & badv_rd)
              | ({XLEN{hit_eentry}} & eentry_rd)
              | ({XLEN{hit_tid}}    & tid_rd)
              | ({XLEN{hit_tcfg}}   & tcfg_rd)
              | ({XLEN{hit_tval}}   & tval_rd);
        for (int i = 0; i < NUM_SAVE; i++) begin
            rdata = rdata | ({XLEN{hit_save[i]}} & save_rd[i]);
        end
    end

    assign csr_rvalue = csr_re ? rdata : '0;

endmodule

// ==== design/csr_except.sv ====
`timescale 1ns/1ps

module csr_except import csr_pkg::*; #(
    parameter int NUM_SAVE = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           wr_crmd,
    input  logic                           wr_prmd,
    input  logic                           wr_ecfg,
    input  logic                           wr_estat,
    input  logic                           wr_era,
    input  logic                           wr_badv,
    input  logic                           wr_eentry,
    input  logic [NUM_SAVE-1:0]            wr_save,
    input  logic                           wr_ticlr,
    input  logic [XLEN-1:0]                csr_wmask,
    input  logic [XLEN-1:0]                csr_wvalue,
    input  logic                           wb_ex,
    input  ecode_e                         wb_ecode,
    input  logic [ESUBCODE_W-1:0]          wb_esubcode,
    input  logic [XLEN-1:0]                wb_pc,
    input  logic [XLEN-1:0]                wb_vaddr,
    input  logic                           ertn_flush,
    input  logic [HWI_W-1:0]               hw_int,
    input  logic                           ipi_int,
    input  logic                           timer_fire,
    output logic [XLEN-1:0]                crmd_rd,
    output logic [XLEN-1:0]                prmd_rd,
    output logic [XLEN-1:0]                ecfg_rd,
    output logic [XLEN-1:0]                estat_rd,
    output logic [XLEN-1:0]                era_rd,
    output logic [XLEN-1:0]                badv_rd,
    output logic [XLEN-1:0]                eentry_rd,
    output logic [NUM_SAVE-1:0][XLEN-1:0]  save_rd,
    output logic [XLEN-1:0]                csr_eentry,
    output logic                           has_int
);

    logic [1:0]                     crmd_plv;
    logic                           crmd_ie;
    logic [1:0]                     prmd_pplv;
    logic                           prmd_pie;
    logic [INT_W-1:0]               ecfg_lie;
    logic [INT_W-1:0]               estat_is;
    ecode_e                         estat_ecode;
    logic [ESUBCODE_W-1:0]          estat_esubcode;
    logic [XLEN-1:0]                era;
    logic [XLEN-1:0]                badv;
    logic [XLEN-7:0]                eentry_va;
    logic [NUM_SAVE-1:0][XLEN-1:0]  save_q;
    logic                           is_adef;
    logic                           is_ale;
    logic                           ticlr_clr;
    logic [XLEN-1:0]                crmd_merged;
    logic [XLEN-1:0]                prmd_merged;
    logic [XLEN-1:0]                ecfg_merged;
    logic [XLEN-1:0]                estat_merged;
    logic [XLEN-1:0]                eentry_merged;

    assign is_adef   = (wb_ecode == ECODE_ADEF) && (wb_esubcode == '0);
    assign is_ale    = (wb_ecode == ECODE_ALE);
    assign ticlr_clr = wr_ticlr & csr_wmask[0] & csr_wvalue[0];

    assign crmd_merged   = masked_merge(crmd_rd, csr_wvalue, csr_wmask);
    assign prmd_merged   = masked_merge(prmd_rd, csr_wvalue, csr_wmask);
    assign ecfg_merged   = masked_merge(ecfg_rd, csr_wvalue, csr_wmask);
    assign estat_merged  = masked_merge(estat_rd, csr_wvalue, csr_wmask);
    assign eentry_merged = masked_merge(eentry_rd, csr_wvalue, csr_wmask);

    // da is fixed at 1
    assign crmd_rd   = {{(XLEN-4){1'b0}}, 1'b1, crmd_ie, crmd_plv};
    assign prmd_rd   = {{(XLEN-3){1'b0}}, prmd_pie, prmd_pplv};
    assign ecfg_rd   = {{(XLEN-INT_W){1'b0}}, ecfg_lie};
    assign estat_rd  = {1'b0, estat_esubcode, estat_ecode, 3'b0,
                        estat_is[12:11], 1'b0, estat_is[9:0]};
    assign era_rd    = era;
    assign badv_rd   = badv;
    assign eentry_rd = {eentry_va, 6'b0};
    assign save_rd   = save_q;

    assign csr_eentry = eentry_rd;
    assign has_int    = (|(estat_is[11:0] & ecfg_lie[11:0])) & crmd_ie;

    // privilege state, exception beats ertn beats write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv  <= 2'b0;
            crmd_ie   <= 1'b0;
            prmd_pplv <= 2'b0;
            prmd_pie  <= 1'b0;
        end else begin
            if (wb_ex) begin
                crmd_plv <= 2'b0;
                crmd_ie  <= 1'b0;
            end else if (ertn_flush) begin
                crmd_plv <= prmd_pplv;
                crmd_ie  <= prmd_pie;
            end else if (wr_crmd) begin
                crmd_plv <= crmd_merged[1:0];
                crmd_ie  <= crmd_merged[2];
            end
            if (wb_ex) begin
                prmd_pplv <= crmd_plv;
                prmd_pie  <= crmd_ie;
            end else if (wr_prmd) begin
                prmd_pplv <= prmd_merged[1:0];
                prmd_pie  <= prmd_merged[2];
            end
        end
    end

    // interrupt enables and pending bits, bit 10 stays zero
    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
            estat_is <= '0;
        end else begin
            if (wr_ecfg) begin
                ecfg_lie <= ecfg_merged[INT_W-1:0] & ~(INT_W'(1) << 10);
            end
            if (wr_estat) begin
                estat_is[1:0] <= estat_merged[1:0];
            end
            estat_is[9:2] <= hw_int;
            estat_is[10]  <= 1'b0;
            if (timer_fire) begin
                estat_is[11] <= 1'b1;
            end else if (ticlr_clr) begin
                estat_is[11] <= 1'b0;
            end
            estat_is[12] <= ipi_int;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            estat_ecode    <= ECODE_INT;
            estat_esubcode <= '0;
            era            <= '0;
            badv           <= '0;
            eentry_va      <= '0;
            save_q         <= '0;
        end else begin
            if (wb_ex) begin
                estat_ecode    <= wb_ecode;
                estat_esubcode <= wb_esubcode;
                era            <= wb_pc;
            end else if (wr_era) begin
                era <= masked_merge(era, csr_wvalue, csr_wmask);
            end
            // only address errors record a bad address
            if (wb_ex && (is_adef || is_ale)) begin
                badv <= is_adef ? wb_pc : wb_vaddr;
            end else if (wr_badv) begin
                badv <= masked_merge(badv, csr_wvalue, csr_wmask);
            end
            if (wr_eentry) begin
                eentry_va <= eentry_merged[XLEN-1:6];
            end
            for (int i = 0; i < NUM_SAVE; i++) begin
                if (wr_save[i]) begin
                    save_q[i] <= masked_merge(save_q[i], csr_wvalue, csr_wmask);
                end
            end
        end
    end

endmodule

// ==== design/csr_timer.sv ====
`timescale 1ns/1ps

module csr_timer import csr_pkg::*; #(
    parameter int COUNTER_W = 64
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_tid,
    input  logic                  wr_tcfg,
    input  logic [XLEN-1:0]       csr_wmask,
    input  logic [XLEN-1:0]       csr_wvalue,
    input  logic [XLEN-1:0]       core_id,
    output logic [XLEN-1:0]       tid_rd,
    output logic [XLEN-1:0]       tcfg_rd,
    output logic [XLEN-1:0]       tval_rd,
    output logic                  timer_fire,
    output logic [COUNTER_W-1:0]  stable_counter
);

    logic [XLEN-1:0]      tid;
    logic [XLEN-1:0]      tcfg;
    logic [XLEN-1:0]      tcfg_next;
    logic [XLEN-1:0]      tval;
    logic                 tcfg_en;
    logic                 tcfg_periodic;
    logic [XLEN-1:0]      reload_value;
    logic [COUNTER_W-1:0] counter;

    assign tcfg_next     = masked_merge(tcfg, csr_wvalue, csr_wmask);
    assign tcfg_en       = tcfg[0];
    assign tcfg_periodic = tcfg[1];
    // initval counts in units of four cycles
    assign reload_value  = {tcfg[XLEN-1:2], 2'b00};

    assign tid_rd         = tid;
    assign tcfg_rd        = tcfg;
    assign tval_rd        = tval;
    assign timer_fire     = tcfg_en && (tval == '0);
    assign stable_counter = counter;

    always_ff @(posedge clk) begin
        if (reset) begin
            tid  <= core_id;
            tcfg <= '0;
        end else begin
            if (wr_tid) begin
                tid <= masked_merge(tid, csr_wvalue, csr_wmask);
            end
            if (wr_tcfg) begin
                tcfg <= tcfg_next;
            end
        end
    end

    // all ones means stopped
    always_ff @(posedge clk) begin
        if (reset) begin
            tval <= '1;
        end else if (wr_tcfg && tcfg_next[0]) begin
            tval <= {tcfg_next[XLEN-1:2], 2'b00};
        end else if (tcfg_en && (tval != '1)) begin
            if (tval == '0 && tcfg_periodic) begin
                tval <= reload_value;
            end else begin
                // one-shot wraps to all ones here
                tval <= tval - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            counter <= '0;
        end else begin
            counter <= counter + 1'b1;
        end
    end

endmodule

// ==== design/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit import csr_pkg::*; #(
    parameter int NUM_SAVE  = 4,
    parameter int COUNTER_W = 64
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  csr_re,
    input  logic                  csr_we,
    input  csr_addr_e             csr_num,
    input  logic [XLEN-1:0]       csr_wmask,
    input  logic [XLEN-1:0]       csr_wvalue,
    output logic [XLEN-1:0]       csr_rvalue,
    input  logic                  wb_ex,
    input  ecode_e                wb_ecode,
    input  logic [ESUBCODE_W-1:0] wb_esubcode,
    input  logic [XLEN-1:0]       wb_pc,
    input  logic [XLEN-1:0]       wb_vaddr,
    input  logic                  ertn_flush,
    input  logic [HWI_W-1:0]      hw_int,
    input  logic                  ipi_int,
    input  logic [XLEN-1:0]       core_id,
    output logic [XLEN-1:0]       csr_eentry,
    output logic                  has_int,
    output logic [COUNTER_W-1:0]  stable_counter
);

    logic                           wr_crmd;
    logic                           wr_prmd;
    logic                           wr_ecfg;
    logic                           wr_estat;
    logic                           wr_era;
    logic                           wr_badv;
    logic                           wr_eentry;
    logic [NUM_SAVE-1:0]            wr_save;
    logic                           wr_tid;
    logic                           wr_tcfg;
    logic                           wr_ticlr;

    logic [XLEN-1:0]                crmd_rd;
    logic [XLEN-1:0]                prmd_rd;
    logic [XLEN-1:0]                ecfg_rd;
    logic [XLEN-1:0]                estat_rd;
    logic [XLEN-1:0]                era_rd;
    logic [XLEN-1:0]                badv_rd;
    logic [XLEN-1:0]                eentry_rd;
    logic [NUM_SAVE-1:0][XLEN-1:0]  save_rd;
    logic [XLEN-1:0]                tid_rd;
    logic [XLEN-1:0]                tcfg_rd;
    logic [XLEN-1:0]                tval_rd;
    logic                           timer_fire;

    csr_decode #(.NUM_SAVE(NUM_SAVE)) decode_i (.*);

    csr_except #(.NUM_SAVE(NUM_SAVE)) except_i (.*);

    csr_timer #(.COUNTER_W(COUNTER_W)) timer_i (
        .clk            (clk),
        .reset          (reset),
        .wr_tid         (wr_tid),
        .wr_tcfg        (wr_tcfg),
        .csr_wmask      (csr_wmask),
        .csr_wvalue     (csr_wvalue),
        .core_id        (core_id),
        .tid_rd         (tid_rd),
        .tcfg_rd        (tcfg_rd),
        .tval_rd        (tval_rd),
        .timer_fire     (timer_fire),
        .stable_counter (stable_counter)
    );

endmodule

// ==== test/tb_csr_tasks.svh ====
`ifndef TB_CSR_TASKS_SVH
`define TB_CSR_TASKS_SVH

// 32-bit lcg step
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// expected result of a bit-masked csr write
function automatic logic [31:0] merge_expected(
    input logic [31:0] old_value,
    input logic [31:0] new_value,
    input logic [31:0] mask
);
    return (old_value & ~mask) | (new_value & mask);
endfunction

task automatic csr_write(input logic [13:0] num, input logic [31:0] value,
                         input logic [31:0] mask);
    @(negedge clk);
    csr_re = 1'b0;
    csr_we = 1'b1;
    csr_num = csr_addr_e'(num);
    csr_wvalue = value;
    csr_wmask = mask;
    @(negedge clk);
    csr_we = 1'b0;
endtask

// sampled mid low phase, well before the next rising edge
task automatic csr_read(input logic [13:0] num, output logic [31:0] data);
    @(negedge clk);
    csr_we = 1'b0;
    csr_re = 1'b1;
    csr_num = csr_addr_e'(num);
    #2;
    data = csr_rvalue;
endtask

task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
endtask

task automatic check_equal(input string what, input logic [31:0] got,
                           input logic [31:0] expected);
    check_count++;
    assert (got === expected)
    else begin
        error_count++;
        $display("FAIL @%0t: %s got 0x%08h expected 0x%08h", $time, what, got, expected);
    end
endtask

task automatic check_true(input string what, input logic cond);
    check_count++;
    assert (cond === 1'b1)
    else begin
        error_count++;
        $display("FAIL @%0t: %s", $time, what);
    end
endtask

`endif

// ==== test/tb_csr_unit.sv ====
`timescale 1ns/1ps

module tb_csr_unit import csr_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam logic [31:0] CORE_ID = 32'h0000_0005;
    localparam logic [31:0] TIMER_INIT = 32'd5;
    localparam logic [31:0] PERIOD_INIT = 32'd3;
    // rough cycle budget of all tests plus slack
    localparam int TEST_CYCLES = 300;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 200;

    logic        clk = 1'b0;
    logic        reset;
    logic        csr_re;
    logic        csr_we;
    csr_addr_e   csr_num;
    logic [31:0] csr_wmask;
    logic [31:0] csr_wvalue;
    logic [31:0] csr_rvalue;
    logic        wb_ex;
    ecode_e      wb_ecode;
    logic [8:0]  wb_esubcode;
    logic [31:0] wb_pc;
    logic [31:0] wb_vaddr;
    logic        ertn_flush;
    logic [7:0]  hw_int;
    logic        ipi_int;
    logic [31:0] core_id;
    logic [31:0] csr_eentry;
    logic        has_int;
    logic [63:0] stable_counter;
    logic [31:0] lcg_state;
    int          check_count;
    int          error_count;

    `include "tb_csr_tasks.svh"

    csr_unit #(.NUM_SAVE(4), .COUNTER_W(64)) dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic raise_exception(input ecode_e code, input logic [8:0] subcode,
                                   input logic [31:0] pc, input logic [31:0] vaddr);
        @(negedge clk);
        wb_ex = 1'b1;
        wb_ecode = code;
        wb_esubcode = subcode;
        wb_pc = pc;
        wb_vaddr = vaddr;
        @(negedge clk);
        wb_ex = 1'b0;
    endtask

    task automatic return_from_exception();
        @(negedge clk);
        ertn_flush = 1'b1;
        @(negedge clk);
        ertn_flush = 1'b0;
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] rd2;
        logic [31:0] shadow [6];
        logic [31:0] value;
        logic [31:0] mask;
        logic [31:0] expected;
        logic [31:0] pc;
        logic [31:0] vaddr;
        logic [13:0] num;
        logic [63:0] count_first;
        int          k;

        reset = 1'b1;
        csr_re = 1'b0;
        csr_we = 1'b0;
        csr_num = CSR_CRMD;
        csr_wmask = '0;
        csr_wvalue = '0;
        wb_ex = 1'b0;
        wb_ecode = ECODE_INT;
        wb_esubcode = '0;
        wb_pc = '0;
        wb_vaddr = '0;
        ertn_flush = 1'b0;
        hw_int = '0;
        ipi_int = 1'b0;
        core_id = CORE_ID;
        lcg_state = 32'h3e2e_4a7e;
        check_count = 0;
        error_count = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // reset values
        csr_read(CSR_CRMD, rd);
        check_equal("crmd after reset", rd, 32'h8);
        csr_read(CSR_TVAL, rd);
        check_equal("tval after reset", rd, 32'hffff_ffff);
        csr_read(CSR_TID, rd);
        check_equal("tid after reset", rd, CORE_ID);
        check_true("has_int low after reset", has_int == 1'b0);
        @(negedge clk);
        csr_re = 1'b0;
        #2;
        check_equal("read with csr_re low", csr_rvalue, 32'h0);

        // masked writes to save0-3, era, eentry, all zero after reset
        for (int j = 0; j < 6; j++) begin
            shadow[j] = '0;
        end
        for (int round = 0; round < 2; round++) begin
            for (int i = 0; i < 6; i++) begin
                case (i)
                    4: num = CSR_ERA;
                    5: num = CSR_EENTRY;
                    default: num = 14'(CSR_SAVE0) + 14'(i);
                endcase
                value = lcg_next();
                mask = lcg_next();
                csr_write(num, value, mask);
                csr_read(num, rd);
                expected = merge_expected(shadow[i], value, mask);
                if (i == 5) begin
                    expected = expected & ~32'h3f;
                    check_equal("eentry output port", csr_eentry, expected);
                end
                shadow[i] = expected;
                check_equal($sformatf("masked write to csr 0x%0h", num), rd, expected);
            end
        end

        // exception entry and return
        csr_write(CSR_CRMD, 32'h7, 32'h7);
        csr_read(CSR_CRMD, rd);
        check_equal("crmd plv 3 ie 1", rd, 32'hf);
        pc = lcg_next();
        vaddr = lcg_next();
        raise_exception(ECODE_ALE, 9'h0, pc, vaddr);
        csr_read(CSR_CRMD, rd);
        check_equal("crmd after ale entry", rd, 32'h8);
        csr_read(CSR_PRMD, rd);
        check_equal("prmd after ale entry", rd, 32'h7);
        csr_read(CSR_ERA, rd);
        check_equal("era after ale entry", rd, pc);
        csr_read(CSR_BADV, rd);
        check_equal("badv after ale entry", rd, vaddr);
        csr_read(CSR_ESTAT, rd);
        check_equal("estat ecode after ale", 32'(rd[21:16]), 32'h9);
        return_from_exception();
        csr_read(CSR_CRMD, rd);
        check_equal("crmd after ertn", rd, 32'hf);
        pc = lcg_next();
        vaddr = lcg_next();
        raise_exception(ECODE_ADEF, 9'h0, pc, vaddr);
        csr_read(CSR_BADV, rd);
        check_equal("badv after adef entry", rd, pc);
        csr_read(CSR_ESTAT, rd);
        check_equal("estat ecode after adef", 32'(rd[21:16]), 32'h8);

        // one-shot timer, loaded at the edge after the write
        csr_write(CSR_TCFG, (TIMER_INIT << 2) | 32'h1, 32'hffff_ffff);
        csr_read(CSR_TVAL, rd);
        check_equal("tval one cycle after load", rd, TIMER_INIT * 4 - 1);
        k = 7;
        idle_cycles(k - 1);
        csr_read(CSR_TVAL, rd2);
        check_equal("tval countdown over k cycles", rd - rd2, 32'(k));
        idle_cycles(int'(TIMER_INIT) * 4 - 1 - k);
        csr_read(CSR_TVAL, rd);
        check_equal("one-shot tval after expiry", rd, 32'hffff_ffff);
        idle_cycles(5);
        csr_read(CSR_TVAL, rd);
        check_equal("one-shot tval stays stopped", rd, 32'hffff_ffff);
        csr_read(CSR_ESTAT, rd);
        check_true("timer pending bit set", rd[11] == 1'b1);
        csr_write(CSR_TICLR, 32'h1, 32'h1);
        csr_read(CSR_ESTAT, rd);
        check_true("timer pending bit cleared by ticlr", rd[11] == 1'b0);
        csr_read(CSR_TICLR, rd);
        check_equal("ticlr reads zero", rd, 32'h0);

        // periodic timer over a few reload periods
        csr_write(CSR_TCFG, (PERIOD_INIT << 2) | 32'h3, 32'hffff_ffff);
        for (int i = 0; i < 45; i++) begin
            csr_read(CSR_TVAL, rd);
            check_true($sformatf("periodic tval 0x%08h in range", rd),
                       rd != 32'hffff_ffff && rd <= PERIOD_INIT * 4);
        end
        csr_write(CSR_TCFG, 32'h0, 32'hffff_ffff);

        // hardware line 0 is pending bit 2
        csr_write(CSR_ECFG, 32'h4, 32'hffff_ffff);
        csr_write(CSR_CRMD, 32'h0, 32'h4);
        hw_int = 8'h01;
        idle_cycles(1);
        #2;
        check_true("has_int low with ie clear", has_int == 1'b0);
        csr_write(CSR_CRMD, 32'h4, 32'h4);
        #2;
        check_true("has_int high once ie set", has_int == 1'b1);
        @(negedge clk);
        hw_int = 8'h00;
        #2;
        check_true("has_int holds until sampled", has_int == 1'b1);
        @(negedge clk);
        #2;
        check_true("has_int low after hw_int drops", has_int == 1'b0);
        @(negedge clk);
        hw_int = 8'h01;
        #2;
        check_true("has_int not yet raised", has_int == 1'b0);
        @(negedge clk);
        #2;
        check_true("has_int one cycle after hw_int", has_int == 1'b1);
        @(negedge clk);
        hw_int = 8'h00;

        // software pending bit 0
        csr_write(CSR_ECFG, 32'h1, 32'hffff_ffff);
        csr_write(CSR_CRMD, 32'h0, 32'h4);
        csr_write(CSR_ESTAT, 32'h1, 32'h3);
        #2;
        check_true("software int masked by ie", has_int == 1'b0);
        csr_write(CSR_CRMD, 32'h4, 32'h4);
        #2;
        check_true("software int raises has_int", has_int == 1'b1);
        csr_write(CSR_ESTAT, 32'h0, 32'h3);
        #2;
        check_true("software int cleared", has_int == 1'b0);

        @(negedge clk);
        count_first = stable_counter;
        k = 10;
        idle_cycles(k);
        check_true($sformatf("stable counter 0x%0h then 0x%0h", count_first, stable_counter),
                   stable_counter - count_first == 64'(k));

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== csr_unit.f ====
design/csr_pkg.sv
design/csr_decode.sv
design/csr_except.sv
design/csr_timer.sv
design/csr_unit.sv
+incdir+test
test/tb_csr_unit.sv

// ==== Makefile ====
# Verilator build and run for the CSR unit testbench

VERILATOR ?= verilator
TOP       ?= tb_csr_unit
FILELIST  ?= csr_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard design/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "failure reported, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "no pass line found in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
